// ==== logic/mesosync_consts.svh ====
// sizing macros for the mesosync input link
// covers the pin line count, the IO period divider width, the logic analyzer
// buffer depth and the Wishbone bus widths
`ifndef MESOSYNC_CONSTS_SVH
`define MESOSYNC_CONSTS_SVH

// number of pin lines sampled by the link
`define MESOSYNC_LINES 8

// width of the logic analyzer line selector
`define MESOSYNC_SEL_W 3

// IO period counter width, the period is the divider value plus one
`define MESOSYNC_DIV_W 4

// number of two-bit entries in the logic analyzer buffer
`define MESOSYNC_LA_ELS 8

// Wishbone word index width and data width
`define MESOSYNC_WB_AW 2
`define MESOSYNC_WB_DW 32

`endif

// ==== logic/mesosync_pkg.sv ====
// enum types shared by the mesosync input link
// input mode, register map addresses and logic analyzer FSM states

package mesosync_pkg;

  // what the link does with sampled pins
  typedef enum logic [1:0] {
    IN_STOP   = 2'd0,
    IN_NORMAL = 2'd1,
    IN_LA     = 2'd2
  } input_mode_e;

  // word index of each configuration register
  typedef enum logic [1:0] {
    REG_CTRL  = 2'd0,
    REG_DIV   = 2'd1,
    REG_EDGE  = 2'd2,
    REG_PHASE = 2'd3
  } reg_addr_e;

  // logic analyzer capture and readout states
  typedef enum logic [1:0] {
    LA_IDLE  = 2'd0,
    LA_ARMED = 2'd1,
    LA_FILL  = 2'd2,
    LA_DRAIN = 2'd3
  } la_state_e;

endpackage

// ==== logic/mesosync_cfg_regs.sv ====
// Wishbone classic slave for the mesosync link configuration
// holds control, divider, edge mask and per-line phase registers
// single-cycle ack, writes land on the ack edge

`include "mesosync_consts.svh"

module mesosync_cfg_regs import mesosync_pkg::*; (
  input  logic                                         clk,
  input  logic                                         channel_reset,
  input  logic                                         wb_cyc_i,
  input  logic                                         wb_stb_i,
  input  logic                                         wb_we_i,
  input  logic [`MESOSYNC_WB_AW-1:0]                   wb_adr_i,
  input  logic [`MESOSYNC_WB_DW-1:0]                   wb_dat_i,
  output logic [`MESOSYNC_WB_DW-1:0]                   wb_dat_o,
  output logic                                         wb_ack_o,
  output logic                                         enable_o,
  output input_mode_e                                  mode_o,
  output logic                                         la_enque_o,
  output logic [`MESOSYNC_SEL_W-1:0]                   la_sel_o,
  output logic [`MESOSYNC_DIV_W-1:0]                   div_o,
  output logic [`MESOSYNC_LINES-1:0]                   edge_mask_o,
  output logic [`MESOSYNC_LINES*`MESOSYNC_DIV_W-1:0]   phase_o
);

  logic                       req;
  reg_addr_e                  addr;
  logic [`MESOSYNC_WB_DW-1:0] rd_data;

  // a new request is one the slave has not acknowledged yet
  assign req  = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign addr = reg_addr_e'(wb_adr_i);

  // ----------------------------------------
  // read mux
  // ----------------------------------------
  // undefined bits stay zero
  always_comb begin
    rd_data = '0;
    case (addr)
      REG_CTRL:  rd_data[6:0] = {la_sel_o, la_enque_o, mode_o, enable_o};
      REG_DIV:   rd_data[`MESOSYNC_DIV_W-1:0] = div_o;
      REG_EDGE:  rd_data[`MESOSYNC_LINES-1:0] = edge_mask_o;
      REG_PHASE: rd_data[`MESOSYNC_LINES*`MESOSYNC_DIV_W-1:0] = phase_o;
      default:   rd_data = '0;
    endcase
  end

  // ----------------------------------------
  // ack, read data and register writes
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (channel_reset) begin
      wb_ack_o    <= 1'b0;
      wb_dat_o    <= '0;
      enable_o    <= 1'b0;
      mode_o      <= IN_STOP;
      la_enque_o  <= 1'b0;
      la_sel_o    <= '0;
      div_o       <= '0;
      edge_mask_o <= '0;
      phase_o     <= '0;
    end else begin
      // ack follows the request by one cycle and drops right after
      wb_ack_o <= req;
      if (req & ~wb_we_i) begin
        wb_dat_o <= rd_data;
      end
      if (req & wb_we_i) begin
        case (addr)
          REG_CTRL: begin
            enable_o   <= wb_dat_i[0];
            mode_o     <= input_mode_e'(wb_dat_i[2:1]);
            la_enque_o <= wb_dat_i[3];
            la_sel_o   <= wb_dat_i[6:4];
          end
          REG_DIV:   div_o       <= wb_dat_i[`MESOSYNC_DIV_W-1:0];
          REG_EDGE:  edge_mask_o <= wb_dat_i[`MESOSYNC_LINES-1:0];
          REG_PHASE: phase_o     <= wb_dat_i[`MESOSYNC_LINES*`MESOSYNC_DIV_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // the master holds its request, so a second ack in a row would double a write
  ack_single_cycle: assert property (
    @(posedge clk) disable iff (channel_reset)
    wb_ack_o |=> !wb_ack_o
  );

endmodule

// ==== logic/ddr_sampler.sv ====
// both-edge sampler for the mesosync pin lines
// rising and falling edge banks aligned to the rising edge
// plus two-stage synchronized copies for the logic analyzer

`include "mesosync_consts.svh"

module ddr_sampler (
  input  logic                       clk,
  input  logic                       channel_reset,
  input  logic [`MESOSYNC_LINES-1:0] pins_i,
  output logic [`MESOSYNC_LINES-1:0] pos_value_o,
  output logic [`MESOSYNC_LINES-1:0] neg_value_o,
  output logic [`MESOSYNC_LINES-1:0] pos_sync_o,
  output logic [`MESOSYNC_LINES-1:0] neg_sync_o
);

  logic [`MESOSYNC_LINES-1:0] pos_r, neg_r, neg_retime_r;
  logic [`MESOSYNC_LINES-1:0] pos_s1_r, pos_s2_r, neg_s1_r, neg_s2_r;

  // falling edge bank sees the pins half a cycle earlier than the rising bank
  always_ff @(negedge clk) begin
    if (channel_reset) neg_r <= '0;
    else               neg_r <= pins_i;
  end

  // ----------------------------------------
  // rising edge bank and synchronizers
  // ----------------------------------------
  // the falling sample is retimed once so both banks present the
  // same pin sample on the same rising edge
  always_ff @(posedge clk) begin
    if (channel_reset) begin
      pos_r        <= '0;
      neg_retime_r <= '0;
      pos_s1_r     <= '0;
      pos_s2_r     <= '0;
      neg_s1_r     <= '0;
      neg_s2_r     <= '0;
    end else begin
      pos_r        <= pins_i;
      neg_retime_r <= neg_r;
      // two extra stages give the analyzer a settled copy
      pos_s1_r     <= pos_r;
      pos_s2_r     <= pos_s1_r;
      neg_s1_r     <= neg_retime_r;
      neg_s2_r     <= neg_s1_r;
    end
  end

  assign pos_value_o = pos_r;
  assign neg_value_o = neg_retime_r;
  assign pos_sync_o  = pos_s2_r;
  assign neg_sync_o  = neg_s2_r;

endmodule

// ==== logic/phase_aligner.sv ====
// per-line phase alignment for the mesosync input link
// runs the IO period counter, picks each line's edge and phase,
// assembles one word per IO period and registers it toward the core

`include "mesosync_consts.svh"

module phase_aligner import mesosync_pkg::*; (
  input  logic                                        clk,
  input  logic                                        channel_reset,
  input  logic                                        enable_i,
  input  input_mode_e                                 mode_i,
  input  logic [`MESOSYNC_DIV_W-1:0]                  div_i,
  input  logic [`MESOSYNC_LINES-1:0]                  edge_mask_i,
  input  logic [`MESOSYNC_LINES*`MESOSYNC_DIV_W-1:0]  phase_i,
  input  logic [`MESOSYNC_LINES-1:0]                  pos_value_i,
  input  logic [`MESOSYNC_LINES-1:0]                  neg_value_i,
  output logic [`MESOSYNC_DIV_W-1:0]                  counter_o,
  output logic [`MESOSYNC_LINES-1:0]                  data_o,
  output logic                                        valid_o
);

  localparam int LINES = `MESOSYNC_LINES;
  localparam int DIV_W = `MESOSYNC_DIV_W;

  logic [DIV_W-1:0] counter_r;
  logic [LINES-1:0] selected;
  logic [LINES-1:0] phase_match;
  logic [LINES-1:0] sampled_r;
  logic [LINES-1:0] line_valid_r;
  logic [LINES-1:0] data_n;
  logic             normal;
  logic             word_ready;

  assign normal = (mode_i == IN_NORMAL);

  // ----------------------------------------
  // IO period counter
  // ----------------------------------------
  // wraps at the divider so the period is div_i + 1 cycles
  // a divider lowered mid-period wraps at once
  always_ff @(posedge clk) begin
    if (channel_reset)          counter_r <= '0;
    else if (counter_r >= div_i) counter_r <= '0;
    else                        counter_r <= counter_r + 1'b1;
  end

  // the analyzer derives its trigger from the same count
  assign counter_o = counter_r;

  // ----------------------------------------
  // edge and phase selection
  // ----------------------------------------
  always_comb begin
    for (int i = 0; i < LINES; i++) begin
      // a set mask bit takes the rising edge sample
      selected[i]    = edge_mask_i[i] ? pos_value_i[i] : neg_value_i[i];
      phase_match[i] = (counter_r == phase_i[i*DIV_W +: DIV_W]);
      // lines matching this cycle bypass their latch
      data_n[i]      = phase_match[i] ? selected[i] : sampled_r[i];
    end
  end

  // the word is complete once every line is latched or matching now
  assign word_ready = normal & (&(line_valid_r | phase_match));

  // each line holds its sample for the rest of the period
  always_ff @(posedge clk) begin
    if (normal) begin
      for (int i = 0; i < LINES; i++) begin
        if (phase_match[i]) sampled_r[i] <= selected[i];
      end
    end
  end

  // per-line valid bits collect matches and clear when the word goes out
  always_ff @(posedge clk) begin
    if (channel_reset || !normal) line_valid_r <= '0;
    else if (word_ready)          line_valid_r <= '0;
    else                          line_valid_r <= line_valid_r | phase_match;
  end

  // ----------------------------------------
  // output register toward the core
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (channel_reset) begin
      valid_o <= 1'b0;
      data_o  <= '0;
    end else begin
      valid_o <= word_ready & enable_i;
      if (word_ready & enable_i) data_o <= data_n;
    end
  end

  // words only come out of a period spent in normal mode
  valid_needs_normal: assert property (
    @(posedge clk) disable iff (channel_reset)
    valid_o |-> $past(mode_i) == IN_NORMAL
  );

endmodule

// ==== logic/logic_analyzer.sv ====
// one-line logic analyzer for the mesosync input link
// captures synchronized rising and falling samples of the selected line
// from a period start, then streams them out over valid/ready

`include "mesosync_consts.svh"

module logic_analyzer import mesosync_pkg::*; (
  input  logic                       clk,
  input  logic                       channel_reset,
  input  input_mode_e                mode_i,
  input  logic                       la_enque_i,
  input  logic [`MESOSYNC_SEL_W-1:0] la_sel_i,
  input  logic [`MESOSYNC_DIV_W-1:0] div_i,
  input  logic [`MESOSYNC_DIV_W-1:0] counter_i,
  input  logic [`MESOSYNC_LINES-1:0] pos_sync_i,
  input  logic [`MESOSYNC_LINES-1:0] neg_sync_i,
  input  logic                       la_ready_i,
  output logic                       la_data_o,
  output logic                       la_valid_o
);

  localparam int ELS   = `MESOSYNC_LA_ELS;
  localparam int DIV_W = `MESOSYNC_DIV_W;
  localparam int WR_W  = $clog2(ELS);
  localparam int RD_W  = $clog2(2 * ELS);

  la_state_e       state_r;
  logic [1:0]      buf_r [ELS];
  logic [WR_W-1:0] wr_ptr_r;
  logic [RD_W-1:0] rd_ptr_r;
  logic            spent_r;
  logic            period_start;
  logic            sample_we;
  logic [1:0]      sample;
  logic [1:0]      rd_entry;

  // synchronized samples trail the counter by two cycles
  // below a divider of 2 the shift folds back onto count zero
  assign period_start = (div_i < DIV_W'(2)) ? (counter_i == DIV_W'(0)) :
                                              (counter_i == DIV_W'(2));

  // entry layout keeps the rising sample in bit 0 so it drains first
  assign sample    = {neg_sync_i[la_sel_i], pos_sync_i[la_sel_i]};
  assign sample_we = ((state_r == LA_ARMED) && (mode_i == IN_LA) && period_start) ||
                     (state_r == LA_FILL);

  always_ff @(posedge clk) begin
    if (sample_we) buf_r[wr_ptr_r] <= sample;
  end

  // ----------------------------------------
  // capture and drain FSM
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (channel_reset) begin
      state_r  <= LA_IDLE;
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      spent_r  <= 1'b0;
    end else begin
      // enqueue has to drop before another capture may start
      if (!la_enque_i) spent_r <= 1'b0;
      case (state_r)
        LA_IDLE: begin
          if ((mode_i == IN_LA) && la_enque_i && !spent_r) begin
            state_r <= LA_ARMED;
            spent_r <= 1'b1;
          end
        end
        LA_ARMED: begin
          if (mode_i != IN_LA) begin
            state_r <= LA_IDLE;
          end else if (period_start) begin
            wr_ptr_r <= wr_ptr_r + 1'b1;
            state_r  <= LA_FILL;
          end
        end
        LA_FILL: begin
          // pointer wraps back to zero on the last entry
          wr_ptr_r <= wr_ptr_r + 1'b1;
          if (wr_ptr_r == WR_W'(ELS - 1)) state_r <= LA_DRAIN;
        end
        LA_DRAIN: begin
          if (la_ready_i) begin
            rd_ptr_r <= rd_ptr_r + 1'b1;
            if (rd_ptr_r == RD_W'(2 * ELS - 1)) state_r <= LA_IDLE;
          end
        end
        default: state_r <= LA_IDLE;
      endcase
    end
  end

  // read pointer upper bits pick the entry, bit 0 picks the edge
  assign rd_entry   = buf_r[rd_ptr_r[RD_W-1:1]];
  assign la_valid_o = (state_r == LA_DRAIN);
  assign la_data_o  = la_valid_o & rd_entry[rd_ptr_r[0]];

  // a stalled bit must survive until the host takes it
  la_hold_on_stall: assert property (
    @(posedge clk) disable iff (channel_reset)
    (state_r == LA_DRAIN) && !la_ready_i |=> (state_r == LA_DRAIN) && $stable(la_data_o)
  );

endmodule

// ==== logic/mesosync_input.sv ====
// top level of the mesosync input link
// Wishbone configuration, both-edge pin sampler, phase aligner
// toward the core and the one-line logic analyzer

`include "mesosync_consts.svh"

module mesosync_input import mesosync_pkg::*; (
  input  logic                       clk,
  input  logic                       channel_reset,
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  logic [`MESOSYNC_WB_AW-1:0] wb_adr_i,
  input  logic [`MESOSYNC_WB_DW-1:0] wb_dat_i,
  output logic [`MESOSYNC_WB_DW-1:0] wb_dat_o,
  output logic                       wb_ack_o,
  input  logic [`MESOSYNC_LINES-1:0] pins_i,
  output logic [`MESOSYNC_LINES-1:0] data_o,
  output logic                       valid_o,
  output logic                       la_data_o,
  output logic                       la_valid_o,
  input  logic                       la_ready_i
);

  // configuration nets
  logic                                       enable;
  input_mode_e                                mode;
  logic                                       la_enque;
  logic [`MESOSYNC_SEL_W-1:0]                 la_sel;
  logic [`MESOSYNC_DIV_W-1:0]                 div;
  logic [`MESOSYNC_LINES-1:0]                 edge_mask;
  logic [`MESOSYNC_LINES*`MESOSYNC_DIV_W-1:0] phase;

  // sampler and counter nets
  logic [`MESOSYNC_LINES-1:0] pos_value, neg_value, pos_sync, neg_sync;
  logic [`MESOSYNC_DIV_W-1:0] counter;

  mesosync_cfg_regs i_cfg_regs (
    .clk(clk), .channel_reset(channel_reset),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
    .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
    .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
    .enable_o(enable), .mode_o(mode), .la_enque_o(la_enque), .la_sel_o(la_sel),
    .div_o(div), .edge_mask_o(edge_mask), .phase_o(phase)
  );

  ddr_sampler i_ddr_sampler (
    .clk(clk), .channel_reset(channel_reset), .pins_i(pins_i),
    .pos_value_o(pos_value), .neg_value_o(neg_value),
    .pos_sync_o(pos_sync), .neg_sync_o(neg_sync)
  );

  // aligned words use the unsynchronized samples for lowest latency
  phase_aligner i_phase_aligner (
    .clk(clk), .channel_reset(channel_reset),
    .enable_i(enable), .mode_i(mode), .div_i(div),
    .edge_mask_i(edge_mask), .phase_i(phase),
    .pos_value_i(pos_value), .neg_value_i(neg_value),
    .counter_o(counter), .data_o(data_o), .valid_o(valid_o)
  );

  logic_analyzer i_logic_analyzer (
    .clk(clk), .channel_reset(channel_reset),
    .mode_i(mode), .la_enque_i(la_enque), .la_sel_i(la_sel),
    .div_i(div), .counter_i(counter),
    .pos_sync_i(pos_sync), .neg_sync_i(neg_sync),
    .la_ready_i(la_ready_i), .la_data_o(la_data_o), .la_valid_o(la_valid_o)
  );

endmodule

// ==== tb/tb_mesosync_input.sv ====
// self-checking testbench for the mesosync input link
// register access, aligned words at several dividers, silent modes
// and logic analyzer readout, all applied from a stimulus table

`include "mesosync_consts.svh"

module tb_mesosync_input import mesosync_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int LINES   = `MESOSYNC_LINES;
  localparam int DW      = `MESOSYNC_WB_DW;
  localparam int LA_BITS = 2 * `MESOSYNC_LA_ELS;
  localparam int ROWS    = 11;

  typedef enum logic {PINS_RANDOM, PINS_HELD} pin_kind_e;

  // one row of stimulus with the outcome the link must show
  typedef struct {
    logic [`MESOSYNC_DIV_W-1:0]       div;
    logic [LINES-1:0]                 edge_mask;
    logic [LINES*`MESOSYNC_DIV_W-1:0] phase;
    logic                             enable;
    input_mode_e                      mode;
    logic [`MESOSYNC_SEL_W-1:0]       la_sel;
    pin_kind_e                        pin_kind;
    logic [LINES-1:0]                 pins;
    int                               window;
    logic                             exp_words;
    logic                             exp_la;
  } row_t;

  logic                       clk, channel_reset;
  logic                       wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
  logic [`MESOSYNC_WB_AW-1:0] wb_adr_i;
  logic [DW-1:0]              wb_dat_i, wb_dat_o;
  logic [LINES-1:0]           pins_i, data_o;
  logic                       valid_o, la_data_o, la_valid_o, la_ready_i;
  logic [31:0]                lcg_state;
  row_t                       rows [ROWS];

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  mesosync_input i_dut (
    .clk(clk), .channel_reset(channel_reset),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
    .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
    .pins_i(pins_i), .data_o(data_o), .valid_o(valid_o),
    .la_data_o(la_data_o), .la_valid_o(la_valid_o), .la_ready_i(la_ready_i)
  );

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // control register layout: enable, mode, enqueue, line select
  function automatic logic [DW-1:0] ctrl_word(logic en, input_mode_e mode, logic enq,
                                               logic [`MESOSYNC_SEL_W-1:0] sel);
    return {25'd0, sel, enq, mode, en};
  endfunction

  // cycles a row may take, writes and settling included
  function automatic int row_budget(row_t r);
    return 60 + 3 * (r.div + 1) + r.window + `MESOSYNC_LA_ELS + 20;
  endfunction

  // every task starts and ends 1 ns after a rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(string name, logic [LINES-1:0] exp, logic [LINES-1:0] got);
    if (got !== exp) report_failure($sformatf("mismatch %s exp %h got %h", name, exp, got));
  endtask

  task automatic check_reg(string name, logic [DW-1:0] exp, logic [DW-1:0] got);
    if (got !== exp) report_failure($sformatf("mismatch %s exp %h got %h", name, exp, got));
  endtask

  task automatic check_bits(string name, logic [LA_BITS-1:0] exp, logic [LA_BITS-1:0] got);
    if (got !== exp) report_failure($sformatf("mismatch %s exp %h got %h", name, exp, got));
  endtask

  task automatic check_flag(string name, logic exp, logic got);
    if (got !== exp) report_failure($sformatf("mismatch %s exp %h got %h", name, exp, got));
  endtask

  // ----------------------------------------
  // Wishbone master
  // ----------------------------------------
  // the request is held until ack, then dropped for the cycle in which ack falls
  task automatic bus_cycle(reg_addr_e addr, logic we, logic [DW-1:0] wdata,
                           output logic [DW-1:0] rdata);
    int waited;
    waited   = 0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = addr;
    wb_dat_i = wdata;
    next_cycle();
    while (wb_ack_o !== 1'b1) begin
      waited++;
      if (waited > 16) report_failure("no Wishbone ack within 16 cycles");
      next_cycle();
    end
    rdata    = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    next_cycle();
  endtask

  task automatic write_reg(reg_addr_e addr, logic [DW-1:0] wdata);
    logic [DW-1:0] unused;
    bus_cycle(addr, 1'b1, wdata, unused);
  endtask

  task automatic read_reg(reg_addr_e addr, output logic [DW-1:0] rdata);
    bus_cycle(addr, 1'b0, '0, rdata);
  endtask

  task automatic test_registers();
    reg_addr_e     addrs [4];
    logic [DW-1:0] wr_val [4];
    logic [DW-1:0] mask [4];
    logic [DW-1:0] rdata;
    addrs  = '{REG_CTRL, REG_DIV, REG_EDGE, REG_PHASE};
    wr_val = '{32'hffff_ff75, 32'h1234_567b, 32'hdead_be5a, 32'h89ab_cdef};
    // defined field widths, everything above them reads zero
    mask   = '{32'h0000_007f, 32'h0000_000f, 32'h0000_00ff, 32'hffff_ffff};
    for (int i = 0; i < 4; i++) begin
      read_reg(addrs[i], rdata);
      check_reg("wb_dat_o", '0, rdata);
    end
    // all writes first so a read can not hide an aliased address
    for (int i = 0; i < 4; i++) write_reg(addrs[i], wr_val[i]);
    for (int i = 0; i < 4; i++) begin
      read_reg(addrs[i], rdata);
      check_reg("wb_dat_o", wr_val[i] & mask[i], rdata);
    end
    write_reg(REG_CTRL, '0);
  endtask

  // ----------------------------------------
  // row checks
  // ----------------------------------------
  // divider 0 gives a word every cycle, two edges after the pins
  task automatic stream_words(row_t r);
    logic [LINES-1:0] old, older;
    logic [31:0]      rnd;
    old   = pins_i;
    older = pins_i;
    for (int c = 0; c < 4 + r.window; c++) begin
      next_cycle();
      if (c >= 4) begin
        check_flag("valid_o", 1'b1, valid_o);
        check_word("data_o", older, data_o);
      end
      rnd        = lcg_next();
      older      = old;
      pins_i     = rnd[23:16];
      old        = pins_i;
      la_ready_i = rnd[28];
    end
  endtask

  // held pins, one word per IO period or none at all in the silent rows
  task automatic count_words(row_t r);
    int count;
    int per;
    count = 0;
    per   = r.div + 1;
    repeat (2 * per + 6) next_cycle();
    for (int c = 0; c < r.window; c++) begin
      next_cycle();
      if (!r.exp_words) check_flag("valid_o", 1'b0, valid_o);
      if (valid_o === 1'b1) begin
        count++;
        check_word("data_o", r.pins, data_o);
      end
    end
    if (r.exp_words && (count < r.window / per - 1 || count > r.window / per + 1))
      report_failure($sformatf("valid_o gave %0d pulses in %0d cycles at divider %0d",
                               count, r.window, r.div));
  endtask

  // the held line value must come back in every drained bit
  task automatic capture_line(row_t r);
    logic [LA_BITS-1:0] got;
    logic [31:0]        rnd;
    int                 nbits;
    int                 waited;
    nbits  = 0;
    waited = 0;
    got    = '0;
    repeat (6) next_cycle();
    write_reg(REG_CTRL, ctrl_word(r.enable, r.mode, 1'b1, r.la_sel));
    while (nbits < LA_BITS) begin
      if (waited > r.window) report_failure("analyzer did not return all sample bits in time");
      rnd        = lcg_next();
      la_ready_i = rnd[28];
      // a bit moves on the coming edge when valid and ready are both high
      if (la_valid_o === 1'b1 && la_ready_i) begin
        got[nbits] = la_data_o;
        nbits++;
      end
      next_cycle();
      waited++;
    end
    check_bits("la_data_o", {LA_BITS{r.exp_la}}, got);
    // enqueue is still high, which must not arm another capture
    repeat (20) begin
      rnd        = lcg_next();
      la_ready_i = rnd[28];
      check_flag("la_valid_o", 1'b0, la_valid_o);
      next_cycle();
    end
  endtask

  task automatic run_row(row_t r);
    logic [31:0] rnd;
    rnd    = lcg_next();
    pins_i = (r.pin_kind == PINS_HELD) ? r.pins : rnd[23:16];
    write_reg(REG_DIV, DW'(r.div));
    write_reg(REG_EDGE, DW'(r.edge_mask));
    write_reg(REG_PHASE, r.phase);
    // enqueue low first, so the analyzer can arm again
    write_reg(REG_CTRL, ctrl_word(r.enable, r.mode, 1'b0, r.la_sel));
    if (r.mode == IN_LA) capture_line(r);
    else if (r.pin_kind == PINS_RANDOM) stream_words(r);
    else count_words(r);
  endtask

  // columns: div, edge mask, phases, enable, mode, line select, pin kind,
  // held pins, window or drain limit, words expected, analyzer bit
  function automatic void load_table();
    rows[0]  = '{4'd0, 8'hff, 32'h0000_0000, 1'b1, IN_NORMAL, 3'd0, PINS_RANDOM, 8'h00, 40, 1'b1, 1'b0};
    rows[1]  = '{4'd0, 8'h00, 32'h0000_0000, 1'b1, IN_NORMAL, 3'd0, PINS_RANDOM, 8'h00, 40, 1'b1, 1'b0};
    rows[2]  = '{4'd0, 8'ha5, 32'h0000_0000, 1'b1, IN_NORMAL, 3'd0, PINS_RANDOM, 8'h00, 40, 1'b1, 1'b0};
    rows[3]  = '{4'd1, 8'h3c, 32'h1010_0101, 1'b1, IN_NORMAL, 3'd0, PINS_HELD,   8'h96, 40, 1'b1, 1'b0};
    rows[4]  = '{4'd2, 8'h0f, 32'h2102_1021, 1'b1, IN_NORMAL, 3'd0, PINS_HELD,   8'h5a, 45, 1'b1, 1'b0};
    rows[5]  = '{4'd3, 8'hf0, 32'h3210_0123, 1'b1, IN_NORMAL, 3'd0, PINS_HELD,   8'hc3, 48, 1'b1, 1'b0};
    rows[6]  = '{4'd2, 8'hff, 32'h0000_0000, 1'b1, IN_STOP,   3'd0, PINS_HELD,   8'h3c, 30, 1'b0, 1'b0};
    rows[7]  = '{4'd1, 8'h00, 32'h1111_0000, 1'b0, IN_NORMAL, 3'd0, PINS_HELD,   8'h69, 30, 1'b0, 1'b0};
    rows[8]  = '{4'd0, 8'hff, 32'h0000_0000, 1'b1, IN_LA,     3'd0, PINS_HELD,   8'ha5, 200, 1'b0, 1'b1};
    rows[9]  = '{4'd0, 8'hff, 32'h0000_0000, 1'b1, IN_LA,     3'd1, PINS_HELD,   8'ha5, 200, 1'b0, 1'b0};
    rows[10] = '{4'd3, 8'hff, 32'h0000_0000, 1'b1, IN_LA,     3'd6, PINS_HELD,   8'h5a, 200, 1'b0, 1'b1};
  endfunction

  // ----------------------------------------
  // watchdog and main sequence
  // ----------------------------------------
  initial begin : watchdog
    int budget;
    #1;
    // reset and register checks, then every row
    budget = 200;
    for (int i = 0; i < ROWS; i++) budget += row_budget(rows[i]);
    repeat (budget) @(posedge clk);
    report_failure("watchdog expired before the test sequence finished");
  end

  initial begin
    channel_reset = 1'b1;
    wb_cyc_i      = 1'b0;
    wb_stb_i      = 1'b0;
    wb_we_i       = 1'b0;
    wb_adr_i      = '0;
    wb_dat_i      = '0;
    pins_i        = '0;
    la_ready_i    = 1'b0;
    lcg_state     = 32'h4fc3;
    load_table();
    repeat (5) @(posedge clk);
    #1;
    channel_reset = 1'b0;
    check_flag("valid_o", 1'b0, valid_o);
    check_flag("la_valid_o", 1'b0, la_valid_o);
    check_flag("wb_ack_o", 1'b0, wb_ack_o);
    test_registers();
    for (int i = 0; i < ROWS; i++) run_row(rows[i]);
    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+logic
logic/mesosync_pkg.sv
logic/mesosync_cfg_regs.sv
logic/ddr_sampler.sv
logic/phase_aligner.sv
logic/logic_analyzer.sv
logic/mesosync_input.sv
tb/tb_mesosync_input.sv

// ==== Makefile ====
# Verilator build and run of the mesosync input link testbench

TOP := tb_mesosync_input

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fails when the log reports a failure"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	rm -f sim.log
	verilator --binary --timing --timescale 1ns/100ps -Ilogic --top-module $(TOP) \
		-f sources.f --Mdir obj_dir -o $(TOP)
	-./obj_dir/$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "TB FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
